/* design/sysctl_pkg.sv */
// Device map constants assume a 32-bit bus, eight slots and regions packed in index order from 0
package sysctl_pkg;

	// Bus data and address width
	localparam int ARCHBITSZ = 32;

	// Slots on the peripheral interconnect, including the catch-all slot
	localparam int SLAVECOUNT = 8;

	typedef logic [2:0] slv_idx_t;

	localparam slv_idx_t S_SDCARD     = 3'd0;
	localparam slv_idx_t S_DEVTBL     = 3'd1;
	localparam slv_idx_t S_IRQCTRL    = 3'd2;
	localparam slv_idx_t S_SERIAL     = 3'd3;
	localparam slv_idx_t S_RAM        = 3'd4;
	localparam slv_idx_t S_RAMCTRL    = 3'd5;
	localparam slv_idx_t S_BOOTLDR    = 3'd6;
	localparam slv_idx_t S_INVALIDDEV = 3'd7;

	typedef struct packed {
		logic [15:0]          dev_id;
		logic                 useirq;
		logic [ARCHBITSZ-1:0] mapsz;
	} dev_map_t;

	// Region sizes are in bytes
	localparam dev_map_t DEV_MAP [SLAVECOUNT] = '{
		S_SDCARD:     dev_map_t'{16'd4, 1'b1, 32'h0000_1000},
		S_DEVTBL:     dev_map_t'{16'd7, 1'b0, 32'h0000_1000},
		S_IRQCTRL:    dev_map_t'{16'd3, 1'b0, 32'h0000_1000},
		S_SERIAL:     dev_map_t'{16'd5, 1'b1, 32'h0000_1000},
		S_RAM:        dev_map_t'{16'd1, 1'b0, 32'h2000_0000},
		S_RAMCTRL:    dev_map_t'{16'd0, 1'b0, 32'h0001_0000},
		S_BOOTLDR:    dev_map_t'{16'd0, 1'b0, 32'h0000_4000},
		S_INVALIDDEV: dev_map_t'{16'd0, 1'b0, 32'h0000_1000}
	};

	localparam logic [15:0] SOCID = 16'd6;

	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [ARCHBITSZ-1:0] addr;
		logic [ARCHBITSZ-1:0] dat;
	} bus_req_t;

	typedef struct packed {
		logic                 ack;
		logic [ARCHBITSZ-1:0] dat;
	} bus_rsp_t;

	// Decoded software reset request
	typedef struct packed {
		logic cold;
		logic warm;
		logic pwroff;
	} swrst_t;

endpackage

/* design/rst_seq.sv */
// Reset holds for 2**RST_CNTR_BITSZ-1 cycles after the last reload and power-off waits for the button
`timescale 1ns/1ps

module rst_seq
	import sysctl_pkg::*;
#(
	parameter int RST_CNTR_BITSZ = 16
) (
	input  logic       clk_4x_w,
	input  logic       devtbl_rst2_w,
	input  logic       usr_btn_n_i,
	input  logic [1:0] rst_req_i,
	output logic       sys_rst_o,
	output logic       cold_rst_o
);

	swrst_t                    swrst;
	logic                      reload;
	logic [RST_CNTR_BITSZ-1:0] rst_cntr;
	logic                      pwroff_q;
	logic                      cold_q;

	// Both bits is cold, bit 1 alone is warm, bit 0 alone is power-off
	always_comb begin
		swrst.cold   = rst_req_i[1] & rst_req_i[0];
		swrst.warm   = rst_req_i[1] & ~rst_req_i[0];
		swrst.pwroff = ~rst_req_i[1] & rst_req_i[0];
	end

	assign reload = devtbl_rst2_w | ~usr_btn_n_i | swrst.warm | swrst.cold;

	// Down-counter parks at zero once the reset delay has run out
	always_ff @(posedge clk_4x_w) begin
		if (reload) begin
			rst_cntr <= '1;
		end else if (|rst_cntr) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// Power-off stays latched until the user button is pressed
	always_ff @(posedge clk_4x_w) begin
		if (devtbl_rst2_w || !usr_btn_n_i) begin
			pwroff_q <= 1'b0;
		end else if (swrst.pwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	// Previous cold request level, for the rising edge
	always_ff @(posedge clk_4x_w) begin
		if (devtbl_rst2_w) begin
			cold_q <= 1'b0;
		end else begin
			cold_q <= swrst.cold;
		end
	end

	assign cold_rst_o = swrst.cold & ~cold_q;

	assign sys_rst_o = (|rst_cntr) | pwroff_q;

endmodule

/* design/devtbl_regs.sv */
// Single-cycle ack on every accepted request with no stall, and writes outside the control word are dropped
`timescale 1ns/1ps

module devtbl_regs
	import sysctl_pkg::*;
(
	input  logic     clk_4x_w,
	input  logic     devtbl_rst2_w,
	input  logic     sys_rst_i,
	input  bus_req_t req_i,
	output bus_rsp_t rsp_o,
	output logic [1:0] rst_req_o
);

	// Two table words per slot, then the control word
	localparam int CTRL_WORD = 2 * SLAVECOUNT;

	logic [ARCHBITSZ-3:0] word;
	logic                 accept;
	dev_map_t             slot;
	logic [ARCHBITSZ-1:0] rd_data;
	logic [1:0]           rst_req_q;
	logic                 ack_q;
	logic [ARCHBITSZ-1:0] dat_q;

	assign word   = req_i.addr[ARCHBITSZ-1:2];
	assign accept = req_i.cyc & req_i.stb;
	assign slot   = DEV_MAP[word[3:1]];

	always_comb begin
		rd_data = '0;
		if (word < CTRL_WORD) begin
			if (word[0]) begin
				rd_data = slot.mapsz;
			end else begin
				rd_data[15:0]          = slot.dev_id;
				rd_data[ARCHBITSZ-1]   = slot.useirq;
			end
		end else if (word == CTRL_WORD) begin
			rd_data[15:0]  = SOCID;
			rd_data[17:16] = rst_req_q;
		end
	end

	// Request bits drop as soon as the system is in reset
	always_ff @(posedge clk_4x_w) begin
		if (devtbl_rst2_w || sys_rst_i) begin
			rst_req_q <= 2'b00;
		end else if (accept && req_i.we && word == CTRL_WORD) begin
			rst_req_q <= req_i.dat[1:0];
		end
	end

	always_ff @(posedge clk_4x_w) begin
		if (devtbl_rst2_w) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= accept;
		end
	end

	// Read data lines up with ack
	always_ff @(posedge clk_4x_w) begin
		if (accept) begin
			dat_q <= rd_data;
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = dat_q;
	assign rst_req_o = rst_req_q;

endmodule

/* design/addr_dec.sv */
// Regions are contiguous from address 0 in slot order, anything beyond slot 6 lands in the invalid slot
`timescale 1ns/1ps

module addr_dec
	import sysctl_pkg::*;
(
	input  logic                 clk_4x_w,
	input  logic                 devtbl_rst2_w,
	input  logic                 stb_i,
	input  logic [ARCHBITSZ-1:0] addr_i,
	output logic                 vld_o,
	output slv_idx_t             idx_o,
	output logic                 inv_o
);

	// Exclusive end address of slot k
	function automatic logic [ARCHBITSZ-1:0] region_end(input int k);
		logic [ARCHBITSZ-1:0] sum;
		sum = '0;
		for (int i = 0; i <= k; i++) begin
			sum = sum + DEV_MAP[i].mapsz;
		end
		return sum;
	endfunction

	logic [S_INVALIDDEV-1:0] hit;
	slv_idx_t                idx_d;
	logic                    vld_q;

	for (genvar k = 0; k < S_INVALIDDEV; k++) begin : g_region
		assign hit[k] = addr_i < region_end(k);
	end

	// Lowest region that contains the address wins
	always_comb begin
		idx_d = S_INVALIDDEV;
		for (int i = S_INVALIDDEV - 1; i >= 0; i--) begin
			if (hit[i]) begin
				idx_d = slv_idx_t'(i);
			end
		end
	end

	always_ff @(posedge clk_4x_w) begin
		if (devtbl_rst2_w) begin
			vld_q <= 1'b0;
		end else begin
			vld_q <= stb_i;
		end
	end

	always_ff @(posedge clk_4x_w) begin
		if (stb_i) begin
			idx_o <= idx_d;
			inv_o <= ~|hit;
		end
	end

	assign vld_o = vld_q;

endmodule

/* design/sysctl_top.sv */
// One clock domain only, and RST_CNTR_BITSZ sets how long system reset is held
`timescale 1ns/1ps

module sysctl_top
	import sysctl_pkg::*;
#(
	parameter int RST_CNTR_BITSZ = 16
) (
	input  logic                 clk_4x_w,
	input  logic                 devtbl_rst2_w,
	input  logic                 usr_btn_n_i,
	input  bus_req_t             dt_req_i,
	output bus_rsp_t             dt_rsp_o,
	input  logic                 dec_stb_i,
	input  logic [ARCHBITSZ-1:0] dec_addr_i,
	output logic                 sel_vld_o,
	output slv_idx_t             sel_idx_o,
	output logic                 sel_inv_o,
	output logic                 sys_rst_o,
	output logic                 cold_rst_o
);

	// Software reset request levels from the table
	logic [1:0] rst_req_w;

	rst_seq #(
		.RST_CNTR_BITSZ (RST_CNTR_BITSZ)
	) u_rst_seq (
		.clk_4x_w      (clk_4x_w),
		.devtbl_rst2_w (devtbl_rst2_w),
		.usr_btn_n_i   (usr_btn_n_i),
		.rst_req_i     (rst_req_w),
		.sys_rst_o     (sys_rst_o),
		.cold_rst_o    (cold_rst_o)
	);

	// System reset also clears the request bits it came from
	devtbl_regs u_devtbl (
		.clk_4x_w      (clk_4x_w),
		.devtbl_rst2_w (devtbl_rst2_w),
		.sys_rst_i     (sys_rst_o),
		.req_i         (dt_req_i),
		.rsp_o         (dt_rsp_o),
		.rst_req_o     (rst_req_w)
	);

	addr_dec u_addr_dec (
		.clk_4x_w      (clk_4x_w),
		.devtbl_rst2_w (devtbl_rst2_w),
		.stb_i         (dec_stb_i),
		.addr_i        (dec_addr_i),
		.vld_o         (sel_vld_o),
		.idx_o         (sel_idx_o),
		.inv_o         (sel_inv_o)
	);

endmodule

/* tests/tb_ref.svh */
// Expected values come from the documented device map and assume RST_CNTR_BITSZ is 4 in the DUT
`ifndef TB_REF_SVH
`define TB_REF_SVH

// Compares two words and logs a mismatch with the time
task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
	chk_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("[ERROR] %0t: %s got %h expected %h", $time, msg, got, exp);
	end
endtask

// Region size in bytes of each slot
function automatic logic [31:0] slot_size(input int k);
	case (k)
		4: return 32'h2000_0000;
		5: return 32'h0001_0000;
		6: return 32'h0000_4000;
		default: return 32'h0000_1000;
	endcase
endfunction

// Start address of slot k, regions packed in index order from 0
function automatic logic [31:0] region_base(input int k);
	logic [31:0] base;
	base = '0;
	for (int i = 0; i < k; i++) begin
		base = base + slot_size(i);
	end
	return base;
endfunction

function automatic logic [31:0] ref_read(input int word, input logic [1:0] req);
	logic [31:0] d;
	d = '0;
	if (word == 16) begin
		d = {14'd0, req, 16'd6};
	end else if (word < 16 && word % 2 == 1) begin
		d = slot_size(word / 2);
	end else if (word < 16) begin
		// useirq in bit 31, ID in the low half
		case (word / 2)
			0: d = 32'h8000_0004;
			1: d = 32'h0000_0007;
			2: d = 32'h0000_0003;
			3: d = 32'h8000_0005;
			4: d = 32'h0000_0001;
			default: d = '0;
		endcase
	end
	return d;
endfunction

// Result is {inv, idx}
function automatic logic [3:0] ref_decode(input logic [31:0] addr);
	for (int k = 0; k < 7; k++) begin
		if (addr < region_base(k + 1)) begin
			return {1'b0, 3'(k)};
		end
	end
	return 4'b1111;
endfunction

function automatic swrst_t ref_swrst(input logic [1:0] req);
	swrst_t s;
	s.cold   = (req == 2'b11);
	s.warm   = (req == 2'b10);
	s.pwroff = (req == 2'b01);
	return s;
endfunction

`endif

/* tests/tb_sysctl.sv */
// Runs with a 4-bit reset counter, so a plain reset release takes 15 cycles
`timescale 1ns/1ps

module tb_sysctl
	import sysctl_pkg::*;
();

	localparam int TMO = 200;

	typedef struct packed {
		logic        rd;
		logic [31:0] cyc;
		logic [31:0] dat;
	} bus_exp_t;

	typedef struct packed {
		logic [31:0] cyc;
		logic [3:0]  res;
	} dec_exp_t;

	logic        clk_4x_w;
	logic        devtbl_rst2_w;
	logic        usr_btn_n_i;
	bus_req_t    dt_req;
	bus_rsp_t    dt_rsp;
	logic        dec_stb;
	logic [31:0] dec_addr;
	logic        sel_vld_o;
	slv_idx_t    sel_idx_o;
	logic        sel_inv_o;
	logic        sys_rst_o;
	logic        cold_rst_o;

	int          err_cnt = 0;
	int          chk_cnt = 0;
	int          pulses = 0;
	int          seed = 32'hd7cd_c7bb;
	logic [31:0] cyc_cnt = '0;
	bus_exp_t    bus_q[$];
	dec_exp_t    dec_q[$];

	`include "tb_ref.svh"

	sysctl_top #(.RST_CNTR_BITSZ(4)) uut (
		.clk_4x_w      (clk_4x_w),
		.devtbl_rst2_w (devtbl_rst2_w),
		.usr_btn_n_i   (usr_btn_n_i),
		.dt_req_i      (dt_req),
		.dt_rsp_o      (dt_rsp),
		.dec_stb_i     (dec_stb),
		.dec_addr_i    (dec_addr),
		.sel_vld_o     (sel_vld_o),
		.sel_idx_o     (sel_idx_o),
		.sel_inv_o     (sel_inv_o),
		.sys_rst_o     (sys_rst_o),
		.cold_rst_o    (cold_rst_o)
	);

	always #50 clk_4x_w = ~clk_4x_w;

	always @(posedge clk_4x_w) cyc_cnt <= cyc_cnt + 32'd1;

	task automatic note_timeout(input string msg);
		err_cnt++;
		$display("Timeout: %s", msg);
	endtask

	task automatic send_bus(input logic we, input int word, input logic [31:0] dat,
			input logic [1:0] req);
		bus_exp_t e;
		@(negedge clk_4x_w);
		dt_req.cyc = 1'b1;
		dt_req.stb = 1'b1;
		dt_req.we = we;
		dt_req.addr = {word[29:0], 2'b00};
		dt_req.dat = dat;
		e.rd = ~we;
		e.cyc = cyc_cnt;
		// Read data carries the request bits held when the read is taken
		e.dat = ref_read(word, req);
		bus_q.push_back(e);
	endtask

	task automatic idle_bus();
		@(negedge clk_4x_w);
		dt_req = '0;
	endtask

	task automatic send_decode(input logic [31:0] addr);
		dec_exp_t e;
		@(negedge clk_4x_w);
		dec_stb = 1'b1;
		dec_addr = addr;
		e.cyc = cyc_cnt;
		e.res = ref_decode(addr);
		dec_q.push_back(e);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while ((bus_q.size() != 0 || dec_q.size() != 0) && n < TMO) begin
			@(negedge clk_4x_w);
			n++;
		end
		if (n >= TMO) note_timeout("bus or decode responses still missing");
	endtask

	// Counts cycles until system reset falls
	task automatic count_until_low(output int n);
		n = 0;
		while (sys_rst_o && n < TMO) begin
			@(negedge clk_4x_w);
			n++;
		end
		if (n >= TMO) note_timeout("sys_rst_o never fell");
	endtask

	task automatic run_swreset(input logic [1:0] val);
		swrst_t s;
		int n;
		s = ref_swrst(val);
		pulses = 0;
		send_bus(1'b1, 16, {30'd0, val}, 2'b00);
		// A read right behind the write still sees the request before sys_rst clears it
		send_bus(1'b0, 16, '0, val);
		idle_bus();
		n = 0;
		while (!sys_rst_o && n < TMO) begin
			@(negedge clk_4x_w);
			n++;
		end
		if (n >= TMO) note_timeout("sys_rst_o never rose after the request");
		if (s.pwroff) begin
			// Only the power-off latch holds reset while the counter is idle
			repeat (40) begin
				@(negedge clk_4x_w);
				check(32'(sys_rst_o), 1, "sys_rst_o held in power-off");
			end
			usr_btn_n_i = 1'b0;
			@(negedge clk_4x_w);
			usr_btn_n_i = 1'b1;
			count_until_low(n);
			check(n, 15, "release delay after button");
		end else begin
			count_until_low(n);
			// One extra reload while the request bits clear under sys_rst
			check(n, 16, "software reset length");
		end
		check(pulses, s.cold ? 1 : 0, "cold_rst_o pulse count");
		send_bus(1'b0, 16, '0, 2'b00);
		idle_bus();
		wait_drain();
	endtask

	task automatic report_test(input int num, input string name, input int mark);
		$display("Test %0d %s finished with %0d errors", num, name, err_cnt - mark);
	endtask

	// Cold reset pulses seen anywhere in the run
	always @(negedge clk_4x_w) begin
		if (cold_rst_o === 1'b1) begin
			pulses++;
		end
	end

	// Every ack must come the cycle after its request
	always @(negedge clk_4x_w) begin
		bus_exp_t e;
		if (dt_rsp.ack === 1'b1) begin
			if (bus_q.size() == 0) begin
				err_cnt++;
				$display("Ack at %0t with no request pending", $time);
			end else begin
				e = bus_q.pop_front();
				check(cyc_cnt, e.cyc + 32'd1, "ack cycle");
				if (e.rd) check(dt_rsp.dat, e.dat, "read data");
			end
		end
	end

	always @(negedge clk_4x_w) begin
		dec_exp_t e;
		if (sel_vld_o === 1'b1) begin
			if (dec_q.size() == 0) begin
				err_cnt++;
				$display("Decode result at %0t with no strobe pending", $time);
			end else begin
				e = dec_q.pop_front();
				check(cyc_cnt, e.cyc + 32'd1, "decode cycle");
				check({28'd0, sel_inv_o, sel_idx_o}, {28'd0, e.res}, "decode inv and idx");
			end
		end
	end

	initial begin
		int n;
		int mark;
		logic [31:0] addr;
		clk_4x_w = 1'b0;
		devtbl_rst2_w = 1'b1;
		usr_btn_n_i = 1'b1;
		dt_req = '0;
		dec_stb = 1'b0;
		dec_addr = '0;
		repeat (8) @(negedge clk_4x_w);
		devtbl_rst2_w = 1'b0;

		mark = err_cnt;
		check(32'(sys_rst_o), 1, "sys_rst_o after reset");
		count_until_low(n);
		check(n, 15, "reset release delay");
		check(pulses, 0, "cold_rst_o during release");
		report_test(1, "reset release", mark);

		mark = err_cnt;
		for (int w = 0; w < 18; w++) begin
			send_bus(1'b0, w, '0, 2'b00);
		end
		idle_bus();
		for (int w = 0; w < 18; w++) begin
			send_bus(1'b0, w, '0, 2'b00);
			idle_bus();
		end
		wait_drain();
		report_test(2, "table reads", mark);

		mark = err_cnt;
		for (int i = 0; i < 200; i++) begin
			addr = $random(seed);
			// Half the addresses folded below 1 GB to land in the RAM window
			if (i % 2 == 0) addr[31:30] = 2'b00;
			send_decode(addr);
		end
		for (int k = 0; k < 8; k++) begin
			send_decode(region_base(k) - 32'd1);
			send_decode(region_base(k));
		end
		@(negedge clk_4x_w);
		dec_stb = 1'b0;
		wait_drain();
		report_test(3, "address decode", mark);

		mark = err_cnt;
		run_swreset(2'b10);
		report_test(4, "warm reset", mark);
		mark = err_cnt;
		run_swreset(2'b11);
		report_test(5, "cold reset", mark);
		mark = err_cnt;
		run_swreset(2'b01);
		report_test(6, "power-off", mark);

		$display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+tests
design/sysctl_pkg.sv
design/rst_seq.sv
design/devtbl_regs.sv
design/addr_dec.sv
design/sysctl_top.sv
tests/tb_sysctl.sv

/* Makefile */
SRCS := vlog.f $(wildcard design/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vtb_sysctl: $(SRCS)
	verilator --binary --timing --top-module tb_sysctl -f vlog.f

run: obj_dir/Vtb_sysctl
	@out="$$(./obj_dir/Vtb_sysctl)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
